// File: hdl/aes_consts.svh
/*
  AES-128 width constants, round count, GF(2^8) reduction
  polynomial and first rcon value
*/
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// state and key widths
`define AES_BLOCK_BITS 128
`define AES_WORD_BITS 32
`define AES_BYTE_BITS 8

// full rounds after the initial AddRoundKey
`define AES_ROUNDS 10

// low byte of x^8 + x^4 + x^3 + x + 1
`define AES_POLY 8'h1b

// rcon used for the first key expansion step
`define AES_RCON_FIRST 8'h01

`endif

// File: hdl/aesTypesPkg.sv
/*
  vector types for bytes, words, blocks and round numbers,
  and the round sequencer state enum
*/
`include "aes_consts.svh"

package aesTypesPkg;

  // one state byte
  typedef logic [`AES_BYTE_BITS-1:0] aesByte_t;

  // one column or key word, row 0 byte in the top bits
  typedef logic [`AES_WORD_BITS-1:0] aesWord_t;

  // key, plaintext, state or ciphertext
  // word 0 sits in bits 127..96
  typedef logic [`AES_BLOCK_BITS-1:0] aesBlock_t;

  // round 0 is the initial AddRoundKey, 1..10 the full rounds
  typedef logic [3:0] roundNum_t;

  // round sequencer FSM
  typedef enum logic [1:0] {
    seqIdle,
    seqRun,
    seqDone
  } seqState_t;

endpackage

// File: hdl/aesFieldPkg.sv
/*
  GF(2^8) arithmetic, computed S-box, word rotation and
  substitution for the key schedule, one-column MixColumns
*/
`include "aes_consts.svh"

package aesFieldPkg;
  import aesTypesPkg::*;

  //////////////////////////////
  // field arithmetic
  //////////////////////////////

  // multiply by x: shift left, fold the carry back in
  function automatic aesByte_t xtime(input aesByte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? `AES_POLY : 8'h00);
  endfunction

  // shift-and-add multiply, one xtime per bit of b
  function automatic aesByte_t gfMul(input aesByte_t a, input aesByte_t b);
    aesByte_t acc;
    aesByte_t cur;
    acc = '0;
    cur = a;
    for (int i = 0; i < `AES_BYTE_BITS; i++) begin
      if (b[i]) begin
        acc = acc ^ cur;
      end
      cur = xtime(cur);
    end
    return acc;
  endfunction

  // a^254 as a^2 * a^4 * ... * a^128
  // zero stays zero without a special case
  function automatic aesByte_t gfInv(input aesByte_t a);
    aesByte_t sq;
    aesByte_t acc;
    sq = gfMul(a, a);
    acc = sq;
    for (int i = 0; i < 6; i++) begin
      sq = gfMul(sq, sq);
      acc = gfMul(acc, sq);
    end
    return acc;
  endfunction

  //////////////////////////////
  // substitution and columns
  //////////////////////////////

  // inverse, then affine map: xor of four left rotations plus 63
  function automatic aesByte_t subByte(input aesByte_t a);
    aesByte_t inv;
    inv = gfInv(a);
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  function automatic aesWord_t subWord(input aesWord_t w);
    return {subByte(w[31:24]), subByte(w[23:16]), subByte(w[15:8]), subByte(w[7:0])};
  endfunction

  // [a0 a1 a2 a3] -> [a1 a2 a3 a0]
  function automatic aesWord_t rotWord(input aesWord_t w);
    return {w[23:0], w[31:24]};
  endfunction

  // lightweight form: yi = ai ^ (a0^a1^a2^a3) ^ xtime(ai ^ a(i+1))
  function automatic aesWord_t mixColumn(input aesWord_t col);
    aesByte_t a0, a1, a2, a3;
    aesByte_t sum;
    {a0, a1, a2, a3} = col;
    sum = a0 ^ a1 ^ a2 ^ a3;
    return {a0 ^ sum ^ xtime(a0 ^ a1),
            a1 ^ sum ^ xtime(a1 ^ a2),
            a2 ^ sum ^ xtime(a2 ^ a3),
            a3 ^ sum ^ xtime(a3 ^ a0)};
  endfunction

endpackage

// File: hdl/roundIf.sv
/*
  round control and cipher state shared by the sequencer,
  the round datapath and the result unit
*/
interface roundIf;
  import aesTypesPkg::*;

  // one round per clk while high
  logic stepEn;
  // which transform the datapath applies
  roundNum_t roundNum;
  // key for the round named by roundNum
  aesBlock_t roundKey;
  // current cipher state, ciphertext once done
  aesBlock_t cipherState;

  modport seq (output stepEn, roundNum, roundKey);

  modport dp (input stepEn, roundNum, roundKey, output cipherState);

  modport res (input cipherState);

endinterface

// File: hdl/spiLoader.sv
/*
  sck-domain input shifter for plaintext and key
*/
`include "aes_consts.svh"

module spiLoader (
  input  logic                  sck,
  input  logic                  rstN,
  input  logic                  sdi,
  input  logic                  load,
  output aesTypesPkg::aesBlock_t keyBlock,
  output aesTypesPkg::aesBlock_t textBlock
);
  import aesTypesPkg::*;

  aesBlock_t textNext;
  aesBlock_t keyNext;

  // one 256-bit chain, text on top so the first bit ends at text[127]
  assign {textNext, keyNext} = {textBlock[`AES_BLOCK_BITS-2:0], keyBlock, sdi};

  // shift only while the host holds load
  always_ff @(posedge sck or negedge rstN) begin
    if (!rstN) begin
      textBlock <= '0;
      keyBlock  <= '0;
    end else if (load) begin
      textBlock <= textNext;
      keyBlock  <= keyNext;
    end
  end

endmodule

// File: hdl/roundSequencer.sv
/*
  load synchronizer, round FSM and on-the-fly key expansion
*/
`include "aes_consts.svh"

module roundSequencer (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  load,
  input  aesTypesPkg::aesBlock_t keyBlock,
  roundIf.seq                   rif,
  output logic                  done
);
  import aesTypesPkg::*;
  import aesFieldPkg::*;

  logic      loadMeta;
  logic      loadSync;
  logic      loadPrev;
  logic      startRun;
  seqState_t state;
  roundNum_t roundCnt;
  aesByte_t  rcon;
  aesBlock_t curKey;
  aesWord_t  w0, w1, w2, w3;
  aesWord_t  keyMix;
  aesWord_t  n0, n1, n2, n3;

  //////////////////////////////
  // load synchronizer
  //////////////////////////////

  // two flops into clk, a third to see the falling edge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      loadMeta <= 1'b0;
      loadSync <= 1'b0;
      loadPrev <= 1'b0;
    end else begin
      loadMeta <= load;
      loadSync <= loadMeta;
      loadPrev <= loadSync;
    end
  end

  assign startRun = loadPrev & ~loadSync;

  //////////////////////////////
  // round FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= seqIdle;
      roundCnt <= '0;
      rcon     <= '0;
    end else begin
      case (state)
        seqIdle: begin
          if (startRun) begin
            state    <= seqRun;
            roundCnt <= '0;
            rcon     <= `AES_RCON_FIRST;
          end
        end
        seqRun: begin
          // 01 .. 80 then 1b, 36 through the polynomial fold
          rcon <= xtime(rcon);
          if (roundCnt == `AES_ROUNDS) begin
            state    <= seqDone;
            roundCnt <= '0;
          end else begin
            roundCnt <= roundCnt + 4'd1;
          end
        end
        seqDone: begin
          // host starts the next transfer
          if (loadSync) begin
            state <= seqIdle;
          end
        end
        default: state <= seqIdle;
      endcase
    end
  end

  //////////////////////////////
  // key expansion
  //////////////////////////////

  assign {w0, w1, w2, w3} = curKey;

  // g() of the last word folds in the round constant on row 0
  assign keyMix = subWord(rotWord(w3)) ^ {rcon, {(`AES_WORD_BITS - `AES_BYTE_BITS){1'b0}}};
  assign n0 = w0 ^ keyMix;
  assign n1 = n0 ^ w1;
  assign n2 = n1 ^ w2;
  assign n3 = n2 ^ w3;

  // cipher key on start, next round key after every step
  always_ff @(posedge clk) begin
    if (state == seqIdle && startRun) begin
      curKey <= keyBlock;
    end else if (state == seqRun) begin
      curKey <= {n0, n1, n2, n3};
    end
  end

  assign rif.stepEn   = (state == seqRun);
  assign rif.roundNum = roundCnt;
  assign rif.roundKey = curKey;
  assign done         = (state == seqDone);

endmodule

// File: hdl/cipherRound.sv
/*
  cipher state register and the per-round transforms
*/
`include "aes_consts.svh"

module cipherRound (
  input  logic                  clk,
  input  logic                  rstN,
  input  aesTypesPkg::aesBlock_t textBlock,
  roundIf.dp                    rif
);
  import aesTypesPkg::*;
  import aesFieldPkg::*;

  aesBlock_t cipherReg;
  aesBlock_t subState;
  aesBlock_t shiftState;
  aesBlock_t mixState;
  aesBlock_t nextState;

  // SubBytes on all sixteen bytes
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      subState[8*i +: 8] = subByte(cipherReg[8*i +: 8]);
    end
  end

  // byte (r, c) lives at bits 127 - 32c - 8r
  // row r takes its byte from column c + r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shiftState[127 - 32*c - 8*r -: 8] = subState[127 - 32*((c + r) % 4) - 8*r -: 8];
      end
    end
  end

  // MixColumns, one word per column
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixState[127 - 32*c -: 32] = mixColumn(shiftState[127 - 32*c -: 32]);
    end
  end

  // initial, middle and final rounds differ only in the input to AddRoundKey
  always_comb begin
    if (rif.roundNum == '0) begin
      nextState = textBlock ^ rif.roundKey;
    end else if (rif.roundNum == `AES_ROUNDS) begin
      nextState = shiftState ^ rif.roundKey;
    end else begin
      nextState = mixState ^ rif.roundKey;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cipherReg <= '0;
    end else if (rif.stepEn) begin
      cipherReg <= nextState;
    end
  end

  assign rif.cipherState = cipherReg;

endmodule

// File: hdl/spiResult.sv
/*
  sck-domain ciphertext capture and sdo driver
*/
`include "aes_consts.svh"

module spiResult (
  input  logic sck,
  input  logic rstN,
  input  logic done,
  roundIf.res  rif,
  output logic sdo
);
  import aesTypesPkg::*;

  aesBlock_t captured;
  logic      wasDone;
  logic      sdoDelayed;

  // follow the cipher state until done is seen, then shift out
  always_ff @(posedge sck) begin
    if (!wasDone) begin
      captured <= rif.cipherState;
    end else begin
      captured <= {captured[`AES_BLOCK_BITS-2:0], 1'b0};
    end
  end

  // sdo moves on falling sck so the host samples a settled bit
  always_ff @(negedge sck or negedge rstN) begin
    if (!rstN) begin
      wasDone    <= 1'b0;
      sdoDelayed <= 1'b0;
    end else begin
      wasDone    <= done;
      sdoDelayed <= captured[`AES_BLOCK_BITS-2];
    end
  end

  // msb goes out before the first sck edge of the readback
  assign sdo = (done && !wasDone) ? rif.cipherState[`AES_BLOCK_BITS-1] : sdoDelayed;

endmodule

// File: hdl/aesSpiTop.sv
/*
  AES-128 engine top level with the serial host interface
*/
module aesSpiTop (
  input  logic clk,
  input  logic rstN,
  input  logic sck,
  input  logic sdi,
  input  logic load,
  output logic sdo,
  output logic done
);
  import aesTypesPkg::*;

  // sck-domain blocks, stable once load falls
  aesBlock_t keyBlock;
  aesBlock_t textBlock;

  roundIf rif ();

  spiLoader loader (
    .sck, .rstN, .sdi, .load,
    .keyBlock, .textBlock
  );

  roundSequencer sequencer (
    .clk, .rstN, .load, .keyBlock,
    .rif  (rif.seq),
    .done
  );

  cipherRound datapath (
    .clk, .rstN, .textBlock,
    .rif  (rif.dp)
  );

  spiResult result (
    .sck, .rstN, .done,
    .rif  (rif.res),
    .sdo
  );

endmodule

// File: verification/aes_sva.sv
/*
  concurrent checks on the round sequencer FSM and done,
  bound into the sequencer
*/
`include "aes_consts.svh"

module aesSva (
  input logic                   clk,
  input logic                   rstN,
  input logic                   done,
  input logic                   stepEn,
  input aesTypesPkg::roundNum_t roundCnt
);

  doneInReset: assert property (@(posedge clk) !rstN |-> !done)
    else $error("done high while reset is held");

  // round 0 is AddRoundKey, the last full round is AES_ROUNDS
  roundInRange: assert property (@(posedge clk) disable iff (!rstN)
      roundCnt <= `AES_ROUNDS)
    else $error("round number %0d out of range", roundCnt);

  // the datapath strobe seen at the interface never overlaps done
  stepNotDone: assert property (@(posedge clk) disable iff (!rstN) !(stepEn && done))
    else $error("round step and done high together");

  // done comes only from the final round
  doneAfterLast: assert property (@(posedge clk) disable iff (!rstN)
      $rose(done) |-> $past(stepEn) && $past(roundCnt) == `AES_ROUNDS)
    else $error("done rose without a final round step before it");

endmodule

bind roundSequencer aesSva sequencerChecks (
  .clk, .rstN, .done,
  .stepEn (rif.stepEn),
  .roundCnt
);

// File: verification/aes_tb.sv
/*
  testbench for the AES-128 serial engine: clock, reset, SPI host
  tasks, FIPS-197 directed tests, cycle timeout and closing report
*/
`include "aes_consts.svh"

module aesTb;
  import aesTypesPkg::*;

  // sck phase in clk periods, so one sck cycle spans 8 clk
  localparam int SckHalf = 4;
  // one run: 256 bits in, 128 bits out, plus lead-in and round latency
  localparam int RunCycles = 3 * `AES_BLOCK_BITS * 2 * SckHalf + 64;
  localparam int RunCount = 4;
  // all runs with half again as margin, plus the reset checks
  localparam int CycleLimit = RunCount * RunCycles * 3 / 2 + 200;
  // clk cycles allowed for load-to-done and for done to clear
  localparam int DoneWait = 100;
  localparam int ClearWait = 4;

  logic clk;
  logic rstN;
  logic sck;
  logic sdi;
  logic load;
  logic sdo;
  logic done;

  int errCount = 0;
  int checkCount = 0;
  int cycleCount = 0;

  aesSpiTop uut (.clk, .rstN, .sck, .sdi, .load, .sdo, .done);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // guard against a stuck handshake
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: run passed %0d clk cycles without finishing", CycleLimit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // sck host helpers
  //////////////////////////////

  // low phase, data settles here
  task automatic sckIdle();
    repeat (SckHalf) @(negedge clk);
  endtask

  // high phase, ends on the falling sck edge
  task automatic sckHigh();
    sck = 1'b1;
    repeat (SckHalf) @(negedge clk);
    sck = 1'b0;
  endtask

  // plaintext then key, msb first, while load is high
  task automatic loadBlock(input aesBlock_t text, input aesBlock_t key);
    logic [2*`AES_BLOCK_BITS-1:0] stream;
    int waited;
    stream = {text, key};
    waited = 0;
    @(negedge clk);
    load = 1'b1;
    // a finished run has to give up done once load rises
    if (done) begin
      while (done && waited < ClearWait) begin
        @(negedge clk);
        waited++;
      end
      checkCount++;
      assert (!done) else begin
        errCount++;
        $display("done still high %0d clk cycles after load rose", ClearWait);
      end
    end
    for (int i = 2*`AES_BLOCK_BITS - 1; i >= 0; i--) begin
      sdi = stream[i];
      sckIdle();
      sckHigh();
    end
    sckIdle();
    load = 1'b0;
    sdi  = 1'b0;
  endtask

  task automatic waitDone();
    int waited;
    waited = 0;
    while (!done && waited < DoneWait) begin
      @(negedge clk);
      waited++;
    end
    checkCount++;
    assert (done) else begin
      errCount++;
      $display("done did not rise within %0d clk cycles after load fell", DoneWait);
    end
  endtask

  // msb is on sdo before the first pulse, later bits follow falling sck
  task automatic readBlock(output aesBlock_t got);
    for (int i = `AES_BLOCK_BITS - 1; i >= 0; i--) begin
      sckIdle();
      got[i] = sdo;
      sckHigh();
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  // done must stay quiet while the host leaves load low
  task automatic resetCheck();
    repeat (50) begin
      @(negedge clk);
      checkCount++;
      assert (done === 1'b0) else begin
        errCount++;
        $display("ERR done: expected %h got %h after reset", 1'b0, done);
      end
    end
  endtask

  task automatic encryptCheck(input string name, input aesBlock_t text,
                              input aesBlock_t key, input aesBlock_t expected);
    aesBlock_t got;
    loadBlock(text, key);
    waitDone();
    readBlock(got);
    checkCount++;
    assert (got === expected) else begin
      errCount++;
      $display("ERR sdo (%s): expected %032h got %032h", name, expected, got);
    end
  endtask

  initial begin
    rstN = 1'b0;
    sck  = 1'b0;
    sdi  = 1'b0;
    load = 1'b0;
    repeat (3) @(negedge clk);
    rstN = 1'b1;

    resetCheck();
    // FIPS-197 appendix C.1
    encryptCheck("appendix C.1", 128'h00112233445566778899aabbccddeeff,
                 128'h000102030405060708090a0b0c0d0e0f,
                 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    // appendix B, key schedule must restart from the new key
    encryptCheck("appendix B", 128'h3243f6a8885a308d313198a2e0370734,
                 128'h2b7e151628aed2a6abf7158809cf4f3c,
                 128'h3925841d02dc09fbdc118597196a0b32);
    // zero bytes hit the inverse of zero
    encryptCheck("all zero", '0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
    encryptCheck("appendix C.1 again", 128'h00112233445566778899aabbccddeeff,
                 128'h000102030405060708090a0b0c0d0e0f,
                 128'h69c4e0d86a7b0430d8cdb78070b4c55a);

    $display("checks: %0d  errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+hdl
hdl/aesTypesPkg.sv
hdl/aesFieldPkg.sv
hdl/roundIf.sv
hdl/spiLoader.sv
hdl/roundSequencer.sv
hdl/cipherRound.sv
hdl/spiResult.sv
hdl/aesSpiTop.sv
verification/aes_sva.sv
verification/aes_tb.sv

// File: Makefile
# Verilator build and run for the AES-128 serial engine testbench

VERILATOR ?= verilator
TOP       ?= aesTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# status comes from the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
